//--- hdl/texture_pkg.sv
package texture_pkg;

  // pixel and code widths.
  localparam int PIXEL_W = 8;
  localparam int COUNT_W = 4;

  // a bin address is ci on top of a 4-bit count.
  localparam int BIN_AW = 5;
  localparam int BINS   = 32;
  localparam int HIST_W = 16;

  // readout order of the two histograms.
  typedef enum logic [1:0] {
    RD_NI,
    RD_RD,
    RD_DONE
  } read_stage_e;

endpackage

//--- hdl/pixel_window.sv
`timescale 1ns/10ps

module pixel_window #(
  parameter int COLS = 128,
  parameter int ROWS = 128
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clr_i,
  input  logic [texture_pkg::PIXEL_W-1:0] pixel_i,
  input  logic                          pixel_valid_i,
  output logic [texture_pkg::PIXEL_W-1:0] w0_o,
  output logic [texture_pkg::PIXEL_W-1:0] w1_o,
  output logic [texture_pkg::PIXEL_W-1:0] w2_o,
  output logic [texture_pkg::PIXEL_W-1:0] w3_o,
  output logic [texture_pkg::PIXEL_W-1:0] w4_o,
  output logic [texture_pkg::PIXEL_W-1:0] w5_o,
  output logic [texture_pkg::PIXEL_W-1:0] w6_o,
  output logic [texture_pkg::PIXEL_W-1:0] w7_o,
  output logic [texture_pkg::PIXEL_W-1:0] w8_o,
  output logic                          win_valid_o,
  output logic                          frame_end_o
);
  localparam int W  = texture_pkg::PIXEL_W;
  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);

  logic [W-1:0]  lb0 [COLS];  // previous row.
  logic [W-1:0]  lb1 [COLS];  // the row before that.
  logic [W-1:0]  win_q [9];
  logic [CW-1:0] col_q;
  logic [RW-1:0] row_q;
  logic          last_col;
  logic          last_row;
  logic          win_valid_q;
  logic          frame_end_q;
  logic          ended_q;

  assign last_col = (col_q == CW'(COLS - 1));
  assign last_row = (row_q == RW'(ROWS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
      frame_end_q <= 1'b0;
      ended_q     <= 1'b0;
    end else if (clr_i) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
      frame_end_q <= 1'b0;
      ended_q     <= 1'b0;
    end else begin
      win_valid_q <= pixel_valid_i && (row_q >= RW'(2)) && (col_q >= CW'(2));
      frame_end_q <= pixel_valid_i && last_col && last_row;
      if (frame_end_q) ended_q <= 1'b1;
      if (pixel_valid_i) begin
        if (last_col) begin
          col_q <= '0;
          row_q <= last_row ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // newest column enters on the right, the oldest drops off the left.
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      lb0[col_q] <= pixel_i;
      lb1[col_q] <= lb0[col_q];
      win_q[0]   <= win_q[1];
      win_q[1]   <= win_q[2];
      win_q[2]   <= lb1[col_q];
      win_q[3]   <= win_q[4];
      win_q[4]   <= win_q[5];
      win_q[5]   <= lb0[col_q];
      win_q[6]   <= win_q[7];
      win_q[7]   <= win_q[8];
      win_q[8]   <= pixel_i;
    end
  end

  assign w0_o = win_q[0];
  assign w1_o = win_q[1];
  assign w2_o = win_q[2];
  assign w3_o = win_q[3];
  assign w4_o = win_q[4];
  assign w5_o = win_q[5];
  assign w6_o = win_q[6];
  assign w7_o = win_q[7];
  assign w8_o = win_q[8];
  assign win_valid_o = win_valid_q;
  assign frame_end_o = frame_end_q;

  // a finished frame takes no more pixels until it is cleared.
  a_no_pixel_after_end: assert property (@(posedge clk) disable iff (!rst_n)
    ((frame_end_q || ended_q) && !clr_i) |-> !pixel_valid_i);

endmodule

//--- hdl/median_nine.sv
`timescale 1ns/10ps

module median_nine (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [texture_pkg::PIXEL_W-1:0] w0_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w1_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w2_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w3_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w4_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w5_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w6_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w7_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w8_i,
  input  logic                          valid_i,
  output logic [texture_pkg::PIXEL_W-1:0] med_o,
  output logic                          med_valid_o
);
  localparam int W = texture_pkg::PIXEL_W;

  logic [W-1:0] lo_q [3];
  logic [W-1:0] md_q [3];
  logic [W-1:0] hi_q [3];
  logic [W-1:0] a_q, b_q, c_q;
  logic [W-1:0] med_q;
  logic [2:0]   valid_q;

  function automatic logic [W-1:0] min3(input logic [W-1:0] a, b, c);
    logic [W-1:0] m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  function automatic logic [W-1:0] max3(input logic [W-1:0] a, b, c);
    logic [W-1:0] m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic logic [W-1:0] med3(input logic [W-1:0] a, b, c);
    logic [W-1:0] lo, hi;
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    hi = (hi < c) ? hi : c;
    return (lo > hi) ? lo : hi;
  endfunction

  always_ff @(posedge clk) begin
    lo_q[0] <= min3(w0_i, w1_i, w2_i);  // stage 1 sorts each row.
    md_q[0] <= med3(w0_i, w1_i, w2_i);
    hi_q[0] <= max3(w0_i, w1_i, w2_i);
    lo_q[1] <= min3(w3_i, w4_i, w5_i);
    md_q[1] <= med3(w3_i, w4_i, w5_i);
    hi_q[1] <= max3(w3_i, w4_i, w5_i);
    lo_q[2] <= min3(w6_i, w7_i, w8_i);
    md_q[2] <= med3(w6_i, w7_i, w8_i);
    hi_q[2] <= max3(w6_i, w7_i, w8_i);
    a_q     <= max3(lo_q[0], lo_q[1], lo_q[2]);
    b_q     <= med3(md_q[0], md_q[1], md_q[2]);
    c_q     <= min3(hi_q[0], hi_q[1], hi_q[2]);
    med_q   <= med3(a_q, b_q, c_q);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) valid_q <= '0;
    else valid_q <= {valid_q[1:0], valid_i};
  end

  assign med_o       = med_q;
  assign med_valid_o = valid_q[2];

endmodule

//--- hdl/texture_code.sv
`timescale 1ns/10ps

module texture_code (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [texture_pkg::PIXEL_W-1:0] w0_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w1_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w2_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w3_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w4_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w5_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w6_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w7_i,
  input  logic [texture_pkg::PIXEL_W-1:0] w8_i,
  input  logic                          win_valid_i,
  input  logic                          frame_end_i,
  input  logic [texture_pkg::PIXEL_W-1:0] med_i,
  input  logic                          med_valid_i,
  output logic                          ci_o,
  output logic [texture_pkg::COUNT_W-1:0] ni_o,
  output logic [texture_pkg::COUNT_W-1:0] rd_o,
  output logic                          code_valid_o,
  output logic                          code_last_o
);
  localparam int W  = texture_pkg::PIXEL_W;
  localparam int CN = texture_pkg::COUNT_W;

  logic [9*W-1:0] win_in;
  logic [9*W-1:0] win_q [3];  // matches the three median stages.
  logic [2:0]     valid_q;
  logic [2:0]     end_q;
  logic [W-1:0]   center;
  logic [CN-1:0]  ni_c, rd_c;

  assign win_in = {w8_i, w7_i, w6_i, w5_i, w4_i, w3_i, w2_i, w1_i, w0_i};
  assign center = win_q[2][4*W +: W];

  always_comb begin
    ni_c = '0;
    rd_c = '0;
    for (int k = 0; k < 9; k++) begin
      if (k != 4) begin
        ni_c = ni_c + CN'(win_q[2][k*W +: W] >= med_i);
        rd_c = rd_c + CN'(win_q[2][k*W +: W] >= center);
      end
    end
  end

  always_ff @(posedge clk) begin
    win_q[0] <= win_in;
    win_q[1] <= win_q[0];
    win_q[2] <= win_q[1];
    ci_o     <= (center >= med_i);
    ni_o     <= ni_c;
    rd_o     <= rd_c;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= '0;
      end_q        <= '0;
      code_valid_o <= 1'b0;
      code_last_o  <= 1'b0;
    end else begin
      valid_q      <= {valid_q[1:0], win_valid_i};
      end_q        <= {end_q[1:0], frame_end_i};
      code_valid_o <= med_valid_i && valid_q[2];
      code_last_o  <= end_q[2];
    end
  end

  // the median pipe and the local delay line must stay in step.
  a_median_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    med_valid_i == valid_q[2]);

endmodule

//--- hdl/joint_histogram.sv
`timescale 1ns/10ps

module joint_histogram (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clr_i,
  input  logic                          accum_i,
  input  logic [texture_pkg::BIN_AW-1:0]  bin_i,
  input  logic                          read_step_i,
  output logic [texture_pkg::HIST_W-1:0]  count_o,
  output logic                          count_valid_o,
  output logic                          last_o
);
  localparam int AW = texture_pkg::BIN_AW;
  localparam int CN = texture_pkg::COUNT_W;

  logic [texture_pkg::HIST_W-1:0] bins_q [texture_pkg::BINS];
  logic [AW-1:0]                  rd_ptr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < texture_pkg::BINS; i++) begin
        bins_q[i] <= '0;
      end
    end else if (clr_i) begin
      for (int i = 0; i < texture_pkg::BINS; i++) begin
        bins_q[i] <= '0;
      end
    end else if (accum_i) begin
      bins_q[bin_i] <= bins_q[bin_i] + 1'b1;
    end
  end

  // read pointer walks the bins one step at a time and wraps after the last.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
    end else if (clr_i) begin
      rd_ptr_q <= '0;
    end else if (read_step_i) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign count_o       = bins_q[rd_ptr_q];
  assign count_valid_o = read_step_i;
  assign last_o        = read_step_i && (rd_ptr_q == AW'(texture_pkg::BINS - 1));

  // readout is only legal once the frame has been accumulated.
  a_no_read_during_accum: assert property (@(posedge clk) disable iff (!rst_n)
    !(accum_i && read_step_i));

  // a count of more than eight neighbors cannot come out of a 3x3 window.
  a_bin_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    accum_i |-> (bin_i[CN-1:0] <= CN'(8)));

endmodule

//--- hdl/texture_datapath.sv
`timescale 1ns/10ps

module texture_datapath #(
  parameter int COLS = 128,
  parameter int ROWS = 128
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [texture_pkg::PIXEL_W-1:0] pixel_i,
  input  logic                          pixel_valid_i,
  input  logic                          start_i,
  input  logic                          read_en_i,
  output logic [texture_pkg::HIST_W-1:0]  hist_count_o,
  output logic                          hist_valid_o,
  output logic                          read_finish_o,
  output logic                          frame_done_o,
  output logic                          start_en_o
);
  localparam int W  = texture_pkg::PIXEL_W;
  localparam int CN = texture_pkg::COUNT_W;
  localparam int HW = texture_pkg::HIST_W;

  logic          start_q;
  logic          start_en;
  logic [W-1:0]  w0, w1, w2, w3, w4, w5, w6, w7, w8;
  logic          win_valid, frame_end;
  logic [W-1:0]  med;
  logic          med_valid;
  logic          ci;
  logic [CN-1:0] ni, rd;
  logic          code_valid, code_last;
  logic          step_ni, step_rd;
  logic [HW-1:0] count_ni, count_rd;
  logic          valid_ni, valid_rd;
  logic          last_ni, last_rd;
  texture_pkg::read_stage_e stage_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) start_q <= 1'b0;
    else start_q <= start_i;
  end

  assign start_en   = start_q && !start_i;  // falling edge of start_i.
  assign start_en_o = start_en;

  pixel_window #(.COLS(COLS), .ROWS(ROWS)) u_window (
    .clk(clk), .rst_n(rst_n), .clr_i(start_en), .pixel_i(pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .w0_o(w0), .w1_o(w1), .w2_o(w2), .w3_o(w3), .w4_o(w4),
    .w5_o(w5), .w6_o(w6), .w7_o(w7), .w8_o(w8),
    .win_valid_o(win_valid), .frame_end_o(frame_end)
  );

  median_nine u_median (
    .clk(clk), .rst_n(rst_n),
    .w0_i(w0), .w1_i(w1), .w2_i(w2), .w3_i(w3), .w4_i(w4),
    .w5_i(w5), .w6_i(w6), .w7_i(w7), .w8_i(w8),
    .valid_i(win_valid), .med_o(med), .med_valid_o(med_valid)
  );

  texture_code u_code (
    .clk(clk), .rst_n(rst_n),
    .w0_i(w0), .w1_i(w1), .w2_i(w2), .w3_i(w3), .w4_i(w4),
    .w5_i(w5), .w6_i(w6), .w7_i(w7), .w8_i(w8),
    .win_valid_i(win_valid), .frame_end_i(frame_end),
    .med_i(med), .med_valid_i(med_valid),
    .ci_o(ci), .ni_o(ni), .rd_o(rd),
    .code_valid_o(code_valid), .code_last_o(code_last)
  );

  joint_histogram hist_ni (
    .clk(clk), .rst_n(rst_n), .clr_i(start_en), .accum_i(code_valid),
    .bin_i({ci, ni}), .read_step_i(step_ni),
    .count_o(count_ni), .count_valid_o(valid_ni), .last_o(last_ni)
  );

  joint_histogram hist_rd (
    .clk(clk), .rst_n(rst_n), .clr_i(start_en), .accum_i(code_valid),
    .bin_i({ci, rd}), .read_step_i(step_rd),
    .count_o(count_rd), .count_valid_o(valid_rd), .last_o(last_rd)
  );

  // only one histogram steps at a time, and only while reading is enabled.
  assign step_ni       = read_en_i && !start_en && (stage_q == texture_pkg::RD_NI);
  assign step_rd       = read_en_i && !start_en && (stage_q == texture_pkg::RD_RD);
  assign read_finish_o = read_en_i && (stage_q == texture_pkg::RD_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= texture_pkg::RD_NI;
    end else if (start_en) begin
      stage_q <= texture_pkg::RD_NI;
    end else if (last_ni) begin
      stage_q <= texture_pkg::RD_RD;
    end else if (last_rd) begin
      stage_q <= texture_pkg::RD_DONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist_valid_o <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      hist_valid_o <= !start_en && (valid_ni || valid_rd);
      frame_done_o <= code_last;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_ni) hist_count_o <= count_ni;
    else if (valid_rd) hist_count_o <= count_rd;
  end

endmodule

//--- sim/texture_datapath_tb.sv
`timescale 1ns/10ps

module texture_datapath_tb;

  localparam int COLS      = 10;
  localparam int ROWS      = 8;
  localparam int N_PIX     = COLS * ROWS;
  localparam int INTERIOR  = (COLS - 2) * (ROWS - 2);
  localparam int FRAME_CYC = 2 * N_PIX + 30;  // strobes, random gaps, start and drain.
  localparam int READ_CYC  = 3 * 64 + 10;
  localparam int LIMIT     = 2 * (16 + 4 * FRAME_CYC + 4 * READ_CYC);

  logic        clk;
  logic        rst_n;
  logic [7:0]  pixel_i;
  logic        pixel_valid_i;
  logic        start_i;
  logic        read_en_i;
  logic [15:0] hist_count_o;
  logic        hist_valid_o;
  logic        read_finish_o;
  logic        frame_done_o;
  logic        start_en_o;

  logic [15:0] lfsr;
  int          frame_pix [N_PIX];
  int          exp_words [64];
  int          exp_word;
  int          word_idx;
  int          sum_ni;
  int          sum_rd;
  int          strobe_cnt;
  logic        last_strobe;
  int          cycles;
  int          errors;
  int          tests_run;
  int          tests_bad;
  int          test_err0;
  string       cur_test;

  texture_datapath #(.COLS(COLS), .ROWS(ROWS)) UUT (
    .clk(clk), .rst_n(rst_n), .pixel_i(pixel_i), .pixel_valid_i(pixel_valid_i),
    .start_i(start_i), .read_en_i(read_en_i), .hist_count_o(hist_count_o),
    .hist_valid_o(hist_valid_o), .read_finish_o(read_finish_o),
    .frame_done_o(frame_done_o), .start_en_o(start_en_o)
  );

  always #5 clk = ~clk;

  assign last_strobe = pixel_valid_i && (strobe_cnt == N_PIX - 1);
  assign exp_word    = (word_idx < 64) ? exp_words[word_idx] : 0;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_cnt <= 0;
      word_idx   <= 0;
      sum_ni     <= 0;
      sum_rd     <= 0;
    end else if (start_en_o) begin
      strobe_cnt <= 0;
      word_idx   <= 0;
      sum_ni     <= 0;
      sum_rd     <= 0;
    end else begin
      if (pixel_valid_i) strobe_cnt <= strobe_cnt + 1;
      if (hist_valid_o) begin
        word_idx <= word_idx + 1;
        if (word_idx < 32) sum_ni <= sum_ni + hist_count_o;
        else sum_rd <= sum_rd + hist_count_o;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !hist_valid_o && !read_finish_o && !frame_done_o && !start_en_o)
    else begin
      errors++;
      $display("outputs were not all low after reset was released");
    end

  // high only in the cycle right after start_i falls.
  a_start_edge: assert property (@(posedge clk) disable iff (!rst_n)
    start_en_o == $fell(start_i))
    else begin
      errors++;
      $display("FAILED %s: start_en expected %0d actual %0d", cur_test,
               !$sampled(start_en_o), $sampled(start_en_o));
    end

  a_done_follows: assert property (@(posedge clk) disable iff (!rst_n)
    last_strobe |-> ##6 frame_done_o)
    else begin
      errors++;
      $display("FAILED %s: frame_done 6 cycles after last strobe expected 1 actual 0",
               cur_test);
    end

  a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done_o |-> $past(last_strobe, 6))
    else begin
      errors++;
      $display("frame_done pulsed in %s without a last strobe 6 cycles before", cur_test);
    end

  a_word_value: assert property (@(posedge clk) disable iff (!rst_n)
    hist_valid_o |-> (word_idx < 64) && (hist_count_o == exp_word))
    else begin
      errors++;
      $display("FAILED %s: word %0d expected %0d actual %0d", cur_test,
               $sampled(word_idx), $sampled(exp_word), $sampled(hist_count_o));
    end

  a_finish_count: assert property (@(posedge clk) disable iff (!rst_n)
    read_finish_o |-> (word_idx + hist_valid_o == 64))
    else begin
      errors++;
      $display("FAILED %s: words at read_finish expected 64 actual %0d", cur_test,
               $sampled(word_idx) + $sampled(hist_valid_o));
    end

  // 16-bit Fibonacci register with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic fill_random();
    logic [7:0] v;
    for (int i = 0; i < N_PIX; i++) begin
      draw_bits(8, v);
      frame_pix[i] = v;
    end
  endtask

  task automatic build_model();
    int v [9];
    int s [9];
    int med;
    int ci;
    int ni;
    int rd;
    int t;
    for (int i = 0; i < 64; i++) exp_words[i] = 0;
    for (int r = 1; r < ROWS - 1; r++) begin
      for (int c = 1; c < COLS - 1; c++) begin
        for (int k = 0; k < 9; k++) begin
          v[k] = frame_pix[(r - 1 + k / 3) * COLS + c - 1 + k % 3];
          s[k] = v[k];
        end
        for (int a = 0; a < 8; a++) begin
          for (int b = 0; b < 8 - a; b++) begin
            if (s[b] > s[b + 1]) begin
              t        = s[b];
              s[b]     = s[b + 1];
              s[b + 1] = t;
            end
          end
        end
        med = s[4];
        ci  = (v[4] >= med) ? 1 : 0;
        ni  = 0;
        rd  = 0;
        for (int k = 0; k < 9; k++) begin
          if (k != 4) begin
            ni += (v[k] >= med) ? 1 : 0;
            rd += (v[k] >= v[4]) ? 1 : 0;
          end
        end
        exp_words[ci * 16 + ni]++;
        exp_words[32 + ci * 16 + rd]++;
      end
    end
  endtask

  task automatic start_frame();
    @(posedge clk);
    #1 start_i = 1'b1;
    repeat (3) @(posedge clk);
    #1 start_i = 1'b0;
    @(posedge clk);
  endtask

  task automatic play_frame();
    logic [7:0] r;
    int i;
    i = 0;
    while (i < N_PIX) begin
      @(posedge clk);
      #1;
      draw_bits(2, r);
      if (r == 0) begin
        pixel_valid_i = 1'b0;  // a random gap.
      end else begin
        pixel_valid_i = 1'b1;
        pixel_i       = frame_pix[i][7:0];
        i++;
      end
    end
    @(posedge clk);
    #1 pixel_valid_i = 1'b0;
    while (!frame_done_o) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic read_out(input bit stall);
    logic [7:0] r;
    int hold;
    bit finished;
    hold     = 0;
    finished = 0;
    while (!finished) begin
      @(posedge clk);
      #1;
      if (hold > 0) begin
        read_en_i = 1'b0;
        hold--;
      end else begin
        read_en_i = 1'b1;
        if (stall) begin
          draw_bits(2, r);
          if (r == 0) begin
            draw_bits(2, r);
            hold      = r;
            read_en_i = 1'b0;
          end
        end
      end
      #1 finished = read_finish_o;
    end
    @(posedge clk);  // the last word is still in the output register.
    #1 read_en_i = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    assert (word_idx == 64) else begin
      errors++;
      $display("FAILED %s: word count expected 64 actual %0d", cur_test, word_idx);
    end
    assert (sum_ni == INTERIOR) else begin
      errors++;
      $display("FAILED %s: ni sum expected %0d actual %0d", cur_test, INTERIOR, sum_ni);
    end
    assert (sum_rd == INTERIOR) else begin
      errors++;
      $display("FAILED %s: rd sum expected %0d actual %0d", cur_test, INTERIOR, sum_rd);
    end
  endtask

  task automatic open_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors != test_err0) tests_bad++;
    $display("test %-15s %s (%0d errors)", cur_test,
             (errors == test_err0) ? "ok" : "with errors", errors - test_err0);
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    start_i       = 1'b0;
    read_en_i     = 1'b0;
    lfsr          = 16'd33359;
    cycles        = 0;
    errors        = 0;
    tests_run     = 0;
    tests_bad     = 0;
    for (int i = 0; i < 64; i++) exp_words[i] = 0;

    open_test("reset_start");
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (2) @(posedge clk);
    start_frame();
    close_test();

    open_test("frame_done");
    fill_random();
    build_model();
    play_frame();
    close_test();

    open_test("steady_read");
    read_out(1'b0);
    close_test();

    // the same pixels again, read back with back-pressure.
    open_test("stalled_read");
    start_frame();
    play_frame();
    read_out(1'b1);
    close_test();

    open_test("clear_frame");
    start_frame();
    fill_random();
    build_model();
    play_frame();
    read_out(1'b1);
    close_test();

    // a flat frame puts every interior pixel in bin {1, 8}.
    open_test("constant_frame");
    start_frame();
    for (int i = 0; i < N_PIX; i++) frame_pix[i] = 8'h5a;
    for (int i = 0; i < 64; i++) exp_words[i] = 0;
    exp_words[24]      = INTERIOR;
    exp_words[32 + 24] = INTERIOR;
    play_frame();
    read_out(1'b0);
    close_test();

    $display("tests %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- texture_datapath.f
hdl/texture_pkg.sv
hdl/pixel_window.sv
hdl/median_nine.sv
hdl/texture_code.sv
hdl/joint_histogram.sv
hdl/texture_datapath.sv
sim/texture_datapath_tb.sv

//--- Bender.yml
package:
  name: texture_datapath

sources:
  - hdl/texture_pkg.sv
  - hdl/pixel_window.sv
  - hdl/median_nine.sv
  - hdl/texture_code.sv
  - hdl/joint_histogram.sv
  - hdl/texture_datapath.sv
  - target: test
    files:
      - sim/texture_datapath_tb.sv
